/* project.f */
hdl/px_pkg.sv
hdl/px_state_reg.sv
hdl/px_int_seq.sv
hdl/px_strobe_gen.sv
hdl/px_bus_ctl.sv
hdl/px_top.sv
sim/px_chk.sv
sim/px_tb.sv

/* run.sh */
#!/bin/sh
# Build the P-X testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f project.f \
	--top-module px_tb -Mdir obj_dir -o px_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/px_sim +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_out"

if echo "$sim_out" | grep -q "Test completed successfully"; then
	echo "PASS"
	exit 0
fi

echo "FAIL (simulator exit status $sim_status)"
exit 1

/* sim/px_tb.sv */
/*
	P-X state control testbench
	Random instruction classes, interrupts and bus answers, one forced timeout
*/
`timescale 1ns/1ps

module px_tb;

	localparam int STROB1_SHORT = 2;
	localparam int STROB1_LONG = 4;
	localparam int STROB2_TICKS = 2;
	localparam int ALARM_TICKS = 16;
	localparam int RUN_CYCLES = 200;	// Machine cycles to complete
	localparam int MUTE_AT = 60;	// Machine cycle where memory goes silent
	// Near 12 clocks per machine cycle with bus waits, about 2500 for the run
	localparam int MAX_CLOCKS = 6000;

	logic got;
	logic clo_;
	px_pkg::px_instr_t instr;
	logic irq;
	logic bus_ok;
	logic stop_;
	px_pkg::px_state_t state;
	logic strob1;
	logic strob2;
	logic cyc_end;
	px_pkg::px_bus_t bus;
	logic irq_ack;
	logic awaria;

	logic [31:0] rng = 32'h27d6;	// LCG state
	int clk_cnt = 0;
	int done_cyc = 0;	// Completed machine cycles
	int int_cnt = 0;	// Interrupts taken
	int tmo_cnt = 0;	// Bus timeouts seen
	int ok_delay = 0;	// Req cycles before the next OK
	int stop_wait = 0;	// Cycles left before the STOP pulse
	logic mute = 1'b0;	// Memory not answering
	logic awaria_d = 1'b0;

	px_top #(
		.STROB1_SHORT(STROB1_SHORT),
		.STROB1_LONG(STROB1_LONG),
		.STROB2_TICKS(STROB2_TICKS),
		.ALARM_TICKS(ALARM_TICKS)
	) dut_i (
		.got(got), .clo_(clo_), .instr(instr), .irq(irq), .bus_ok(bus_ok), .stop_(stop_),
		.state(state), .strob1(strob1), .strob2(strob2), .cyc_end(cyc_end), .bus(bus),
		.irq_ack(irq_ack), .awaria(awaria)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output int unsigned v);
		rng = lcg_step(rng);
		v = {16'd0, rng[31:16]};	// Upper half is the better part
	endtask

	task automatic abort_run(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	initial begin
		got = 1'b0;
		forever #4 got = ~got;	// 8 ns period
	end

	// Run limit and checker watch
	always @(posedge got) begin
		clk_cnt <= clk_cnt + 1;
		if (clk_cnt >= MAX_CLOCKS) begin
			abort_run("timeout, the run did not finish within the clock limit");
		end else if (dut_i.chk_i.err_cnt != 0) begin
			abort_run("a protocol assertion failed");
		end
	end

	initial begin
		int unsigned r;
		clo_ = 1'b1;
		instr = '0;
		irq = 1'b0;
		bus_ok = 1'b0;
		stop_ = 1'b1;
		#1 clo_ = 1'b0;	// Clear edge
		repeat (10) @(posedge got);
		#1 clo_ = 1'b1;
		while (done_cyc < RUN_CYCLES || int_cnt < 2 || tmo_cnt < 1) begin
			@(posedge got);
			#1;
			if (cyc_end) begin
				done_cyc++;
			end
			if (!state[px_pkg::PX_K1]) begin
				draw_random(r);
				instr = px_pkg::px_instr_t'(r[1:0]);	// Held through K1
			end
			if (irq_ack) begin
				int_cnt++;
				irq = 1'b0;	// Request served
			end else if (!irq) begin
				draw_random(r);
				if (r % 48 == 0) begin
					irq = 1'b1;
				end
			end
			if (done_cyc == MUTE_AT && tmo_cnt == 0) begin
				mute = 1'b1;	// Force one timeout
			end
			if (awaria && !awaria_d) begin
				tmo_cnt++;
				mute = 1'b0;
				stop_wait = 6;	// Flag sits a while before STOP
			end
			awaria_d = awaria;
			if (!stop_) begin
				stop_ = 1'b1;
			end else if (stop_wait > 0) begin
				stop_wait--;
				if (stop_wait == 0) begin
					stop_ = 1'b0;
				end
			end
			// Memory answers after 0 to 6 request cycles
			if (bus_ok) begin
				bus_ok = 1'b0;
				draw_random(r);
				ok_delay = int'(r % 7);
			end else if (bus.req && !mute) begin
				if (ok_delay == 0) begin
					bus_ok = 1'b1;
				end else begin
					ok_delay--;
				end
			end
		end
		repeat (3) @(posedge got);
		#1;
		if (dut_i.chk_i.err_cnt != 0) begin
			abort_run("a protocol assertion failed");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* sim/px_chk.sv */
/*
	P-X protocol and sequence checker
	Bound to px_top, watches state succession, strobes and the bus handshake
*/
`timescale 1ns/1ps

module px_chk #(
	parameter int STROB1_SHORT = 2,
	parameter int STROB1_LONG = 4,
	parameter int STROB2_TICKS = 2,
	parameter int ALARM_TICKS = 16
) (
	input logic got,
	input logic clo_,
	input px_pkg::px_instr_t instr,
	input logic irq,
	input logic bus_ok,
	input logic stop_,
	input px_pkg::px_state_t state,
	input logic strob1,
	input logic strob2,
	input logic cyc_end,
	input px_pkg::px_bus_t bus,
	input logic irq_ack,
	input logic awaria
);

	int err_cnt = 0;	// Failed checks so far
	int s1_cnt;	// Strobe 1 ticks seen
	int s2_cnt;	// Strobe 2 ticks seen
	int req_age;	// Ticks of req without a drop
	logic pend_m;	// Interrupt waiting for entry
	logic stores_m;	// Store flag of the running instruction
	logic bus_st;	// State uses the bus
	logic long_st;	// Internal operation
	logic exp_write;
	logic [1:0] exp_space;
	px_pkg::px_state_t exp_next;	// Successor by the sequencing rules
	px_pkg::px_state_t exp_q;	// Successor picked at the last cycle end

	task automatic note_failure(input string what);
		err_cnt++;
		$error("%s", what);
	endtask

	// Reference counters and flags
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			s1_cnt <= 0;
			s2_cnt <= 0;
			req_age <= 0;
			pend_m <= 1'b0;
			stores_m <= 1'b0;
			exp_q <= px_pkg::PX_ST_K1;
		end else begin
			s1_cnt <= strob1 ? s1_cnt + 1 : 0;
			s2_cnt <= strob2 ? s2_cnt + 1 : 0;
			req_age <= bus.req ? req_age + 1 : 0;
			if (cyc_end && state == px_pkg::PX_ST_I1) begin
				pend_m <= 1'b0;	// Served by I1
			end else if (irq) begin
				pend_m <= 1'b1;
			end
			if (cyc_end && state == px_pkg::PX_ST_K1) begin
				stores_m <= instr.stores;
			end
			if (cyc_end) begin
				exp_q <= exp_next;
			end
		end
	end

	always_comb begin
		case (state)
			px_pkg::PX_ST_K1: exp_next = instr.has_arg ? px_pkg::PX_ST_K2 : px_pkg::PX_ST_P1;
			px_pkg::PX_ST_K2: exp_next = px_pkg::PX_ST_P1;
			px_pkg::PX_ST_P1: exp_next = stores_m ? px_pkg::PX_ST_WZ
				: (pend_m ? px_pkg::PX_ST_I1 : px_pkg::PX_ST_K1);
			px_pkg::PX_ST_WZ: exp_next = pend_m ? px_pkg::PX_ST_I1 : px_pkg::PX_ST_K1;
			px_pkg::PX_ST_I1: exp_next = px_pkg::PX_ST_I2;
			px_pkg::PX_ST_I2: exp_next = px_pkg::PX_ST_I3;
			px_pkg::PX_ST_I3: exp_next = px_pkg::PX_ST_I4;
			px_pkg::PX_ST_I4: exp_next = px_pkg::PX_ST_I5;
			default: exp_next = px_pkg::PX_ST_K1;	// I5 back to fetch
		endcase
	end

	assign bus_st = |(state & (px_pkg::PX_BUS_READ_MASK | px_pkg::PX_BUS_WRITE_MASK));
	assign exp_write = state[px_pkg::PX_WZ] | state[px_pkg::PX_I2] | state[px_pkg::PX_I3];
	assign long_st = state[px_pkg::PX_P1] | state[px_pkg::PX_I1] | state[px_pkg::PX_I5];

	always_comb begin
		exp_space = px_pkg::PX_SPACE_INT;	// I2, I3, I4
		if (state == px_pkg::PX_ST_K1 || state == px_pkg::PX_ST_K2) begin
			exp_space = px_pkg::PX_SPACE_CODE;
		end else if (state == px_pkg::PX_ST_WZ) begin
			exp_space = px_pkg::PX_SPACE_DATA;
		end
	end

	a_reset: assert property (@(posedge got) !clo_ |-> state == px_pkg::PX_ST_K1 && !strob2
		&& !cyc_end && !bus.req && !irq_ack && !awaria)
		else note_failure("outputs not at their clear values during reset");
	a_first_s1: assert property (@(posedge got) $rose(clo_) |=> strob1)
		else note_failure("strobe 1 did not start right after reset release");
	a_onehot: assert property (@(posedge got) disable iff (!clo_) $onehot(state))
		else note_failure($sformatf("FAIL state %h is not one-hot", $sampled(state)));
	a_next_state: assert property (@(posedge got) disable iff (!clo_) cyc_end |=> state == exp_q)
		else note_failure($sformatf("FAIL state %h expected %h",
			$sampled(state), $sampled(exp_q)));
	a_end_pulse: assert property (@(posedge got) disable iff (!clo_) cyc_end |=> !cyc_end)
		else note_failure("cycle end longer than one clock");
	a_s1_len: assert property (@(posedge got) disable iff (!clo_)
		$fell(strob1) |-> s1_cnt == (long_st ? STROB1_LONG : STROB1_SHORT))
		else note_failure($sformatf("FAIL strob1 length %h expected %h", $sampled(s1_cnt),
			$sampled(long_st) ? STROB1_LONG : STROB1_SHORT));
	a_internal_end: assert property (@(posedge got) disable iff (!clo_)
		$fell(strob1) && !bus_st |-> cyc_end)
		else note_failure("internal cycle did not end right after strobe 1");
	a_wait_start: assert property (@(posedge got) disable iff (!clo_)
		$fell(strob1) && bus_st |-> !bus.req && !cyc_end && !strob2)
		else note_failure("bus cycle did not enter the bus wait");
	a_req_rise: assert property (@(posedge got) disable iff (!clo_)
		$fell(strob1) && bus_st |=> bus.req)
		else note_failure("bus request did not rise after the wait began");
	a_req_fields: assert property (@(posedge got) disable iff (!clo_)
		bus.req |-> bus_st && bus.write == exp_write && bus.space == exp_space)
		else note_failure($sformatf("FAIL bus %h in state %h expected write %h space %h",
			$sampled(bus), $sampled(state), $sampled(exp_write), $sampled(exp_space)));
	a_req_hold: assert property (@(posedge got) disable iff (!clo_)
		bus.req && !bus_ok && req_age < ALARM_TICKS - 1 |=> bus.req)
		else note_failure("bus request dropped before OK or timeout");
	a_req_ok: assert property (@(posedge got) disable iff (!clo_) bus.req && bus_ok |=> !bus.req)
		else note_failure("bus request held after OK");
	a_req_tmo: assert property (@(posedge got) disable iff (!clo_)
		bus.req && !bus_ok && stop_ && req_age == ALARM_TICKS - 1 |=> !bus.req && awaria)
		else note_failure("no-answer timeout did not end the request and set the alarm");
	a_s2_start: assert property (@(posedge got) disable iff (!clo_) $fell(bus.req) |=> strob2)
		else note_failure("strobe 2 did not follow the end of the request");
	a_s2_no_req: assert property (@(posedge got) disable iff (!clo_) strob2 |-> !bus.req)
		else note_failure("strobe 2 while the request is still up");
	a_s2_len: assert property (@(posedge got) disable iff (!clo_)
		$fell(strob2) |-> s2_cnt == STROB2_TICKS && cyc_end)
		else note_failure($sformatf("FAIL strob2 length %h expected %h with cyc_end %h",
			$sampled(s2_cnt), STROB2_TICKS, $sampled(cyc_end)));
	a_alarm_hold: assert property (@(posedge got) disable iff (!clo_) awaria && stop_ |=> awaria)
		else note_failure("alarm flag dropped without STOP");
	a_alarm_clear: assert property (@(posedge got) disable iff (!clo_) !stop_ |=> !awaria)
		else note_failure("alarm flag not cleared by STOP");
	a_ack_where: assert property (@(posedge got) disable iff (!clo_)
		irq_ack |-> cyc_end && state == px_pkg::PX_ST_I1)
		else note_failure("interrupt acknowledge outside the end of I1");
	a_ack_when: assert property (@(posedge got) disable iff (!clo_)
		cyc_end && state == px_pkg::PX_ST_I1 |-> irq_ack)
		else note_failure("end of I1 without interrupt acknowledge");

endmodule

bind px_top px_chk #(
	.STROB1_SHORT(STROB1_SHORT),
	.STROB1_LONG(STROB1_LONG),
	.STROB2_TICKS(STROB2_TICKS),
	.ALARM_TICKS(ALARM_TICKS)
) chk_i (
	.got(got), .clo_(clo_), .instr(instr), .irq(irq), .bus_ok(bus_ok), .stop_(stop_),
	.state(state), .strob1(strob1), .strob2(strob2), .cyc_end(cyc_end), .bus(bus),
	.irq_ack(irq_ack), .awaria(awaria)
);

/* hdl/px_top.sv */
/*
	P-X state control unit top level
	State register, interrupt sequencer, strobe generator, bus controller
*/
`timescale 1ns/1ps

module px_top #(
	parameter int STROB1_SHORT = 2,	// Strobe 1 ticks, ordinary states
	parameter int STROB1_LONG = 4,	// Strobe 1 ticks, P1, I1, I5
	parameter int STROB2_TICKS = 2,	// Strobe 2 ticks
	parameter int ALARM_TICKS = 16	// Bus no-answer timeout
) (
	input logic got,	// Clock
	input logic clo_,	// General clear
	input px_pkg::px_instr_t instr,	// From the decoder
	input logic irq,	// Interrupt request
	input logic bus_ok,	// OK from memory
	input logic stop_,	// Failure flag clear
	output px_pkg::px_state_t state,	// Processor state
	output logic strob1,
	output logic strob2,
	output logic cyc_end,	// Machine cycle end
	output px_pkg::px_bus_t bus,	// System bus request
	output logic irq_ack,	// Interrupt accepted
	output logic awaria	// Bus failure
);

	logic bus_wait;	// Strobe gen waits for the bus
	logic bus_done;	// Bus transfer over
	logic int_take;	// Interrupt entry wanted
	px_pkg::px_state_t int_next;	// I phase successor

	px_state_reg u_state_reg (
		.got(got), .clo_(clo_), .cyc_end(cyc_end), .instr(instr),
		.int_take(int_take), .int_next(int_next), .state(state)
	);

	px_int_seq u_int_seq (
		.got(got), .clo_(clo_), .cyc_end(cyc_end), .irq(irq), .state(state),
		.int_take(int_take), .int_next(int_next), .irq_ack(irq_ack)
	);

	px_strobe_gen #(
		.STROB1_SHORT(STROB1_SHORT),
		.STROB1_LONG(STROB1_LONG),
		.STROB2_TICKS(STROB2_TICKS)
	) u_strobe_gen (
		.got(got), .clo_(clo_), .state(state), .bus_done(bus_done),
		.strob1(strob1), .strob2(strob2), .bus_wait(bus_wait), .cyc_end(cyc_end)
	);

	px_bus_ctl #(
		.ALARM_TICKS(ALARM_TICKS)
	) u_bus_ctl (
		.got(got), .clo_(clo_), .state(state), .bus_wait(bus_wait),
		.bus_ok(bus_ok), .stop_(stop_), .bus(bus), .bus_done(bus_done),
		.awaria(awaria)
	);

endmodule

/* hdl/px_bus_ctl.sv */
/*
	System bus request controller
	Holds ZG until OK or the no-answer timeout, keeps the failure flag
*/
`timescale 1ns/1ps

module px_bus_ctl #(
	parameter int ALARM_TICKS = 16	// Request cycles before giving up
) (
	input logic got,	// Clock
	input logic clo_,	// General clear
	input px_pkg::px_state_t state,	// Current processor state
	input logic bus_wait,	// Cycle waits for the bus
	input logic bus_ok,	// OK from memory
	input logic stop_,	// Clears the failure flag
	output px_pkg::px_bus_t bus,	// Request, direction, space
	output logic bus_done,	// One pulse per transfer
	output logic awaria	// Bus failure
);

	localparam int AW = $clog2(ALARM_TICKS) + 1;

	logic req;	// ZG flip-flop
	logic [AW-1:0] tmo_cnt;	// Cycles without an answer
	logic ok_hit;	// Answer seen this cycle
	logic tmo_hit;	// Last allowed cycle passed unanswered

	assign ok_hit = req & bus_ok;
	assign tmo_hit = req & ~bus_ok & (tmo_cnt == AW'(ALARM_TICKS - 1));

	// Request and completion pulse
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			req <= 1'b0;
			bus_done <= 1'b0;
			tmo_cnt <= '0;
		end else begin
			bus_done <= ok_hit | tmo_hit;	// Drops with req
			if (ok_hit || tmo_hit) begin
				req <= 1'b0;
				tmo_cnt <= '0;
			end else if (req) begin
				tmo_cnt <= tmo_cnt + 1'b1;	// Still waiting
			end else if (bus_wait && !bus_done) begin
				req <= 1'b1;	// Cycle after bus_wait rises
				tmo_cnt <= '0;
			end
		end
	end

	// Failure latch, cleared by STOP
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			awaria <= 1'b0;
		end else if (!stop_) begin
			awaria <= 1'b0;
		end else if (tmo_hit) begin
			awaria <= 1'b1;	// No answer from memory
		end
	end

	// Direction and address space from the state
	always_comb begin
		bus.req = req;
		bus.write = |(state & px_pkg::PX_BUS_WRITE_MASK);
		bus.space = px_pkg::PX_SPACE_CODE;	// K1, K2
		if (state[px_pkg::PX_WZ]) begin
			bus.space = px_pkg::PX_SPACE_DATA;	// Result store
		end else if (state[px_pkg::PX_I2] || state[px_pkg::PX_I3] || state[px_pkg::PX_I4]) begin
			bus.space = px_pkg::PX_SPACE_INT;	// Interrupt save and vector
		end
	end

endmodule

/* hdl/px_strobe_gen.sv */
/*
	Machine cycle strobe generator
	Strobe 1, bus wait, strobe 2 and the cycle end pulse, counted in got
*/
`timescale 1ns/1ps

module px_strobe_gen #(
	parameter int STROB1_SHORT = 2,	// Strobe 1 in ordinary states
	parameter int STROB1_LONG = 4,	// Strobe 1 in internal operations
	parameter int STROB2_TICKS = 2	// Strobe 2 after the bus answer
) (
	input logic got,	// Clock
	input logic clo_,	// General clear
	input px_pkg::px_state_t state,	// Current processor state
	input logic bus_done,	// Bus transfer over
	output logic strob1,	// Strobe 1
	output logic strob2,	// Strobe 2
	output logic bus_wait,	// Cycle held for the bus
	output logic cyc_end	// One-cycle end of machine cycle
);

	// Longest phase sets the counter width
	localparam int MAXT_A = (STROB1_SHORT > STROB1_LONG) ? STROB1_SHORT : STROB1_LONG;
	localparam int MAXT = (MAXT_A > STROB2_TICKS) ? MAXT_A : STROB2_TICKS;
	localparam int CW = $clog2(MAXT) + 1;

	typedef enum logic [2:0] {
		PH_IDLE,	// Only right after clear
		PH_S1,	// Strobe 1
		PH_WAIT,	// Waiting for bus_done
		PH_S2,	// Strobe 2
		PH_END	// Cycle end
	} phase_t;

	phase_t phase;
	logic [CW-1:0] cnt;	// Ticks spent in S1 or S2
	logic [CW-1:0] s1_last;	// Last S1 tick for this state
	logic need_bus;	// State uses the bus
	logic is_long;	// State is an internal operation

	assign need_bus = |(state & (px_pkg::PX_BUS_READ_MASK | px_pkg::PX_BUS_WRITE_MASK));
	assign is_long = |(state & px_pkg::px_state_is_long);
	assign s1_last = is_long ? CW'(STROB1_LONG - 1) : CW'(STROB1_SHORT - 1);

	// Phase sequencing, state is already the new one in S1
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			phase <= PH_IDLE;
			cnt <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					phase <= PH_S1;	// First cycle after clear
					cnt <= '0;
				end
				PH_S1: begin
					if (cnt == s1_last) begin
						phase <= need_bus ? PH_WAIT : PH_END;	// Internal cycles skip the bus
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_WAIT: begin
					if (bus_done) begin
						phase <= PH_S2;	// OK or timeout
					end
				end
				PH_S2: begin
					if (cnt == CW'(STROB2_TICKS - 1)) begin
						phase <= PH_END;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_END: begin
					phase <= PH_S1;	// State changes on this edge
					cnt <= '0;
				end
				default: begin
					phase <= PH_IDLE;
					cnt <= '0;
				end
			endcase
		end
	end

	// Outputs decoded from the phase
	assign strob1 = (phase == PH_S1);
	assign bus_wait = (phase == PH_WAIT);
	assign strob2 = (phase == PH_S2);
	assign cyc_end = (phase == PH_END);

endmodule

/* hdl/px_int_seq.sv */
/*
	Interrupt phase sequencer
	Latches the request, decides on entry and steps I1..I5
*/
`timescale 1ns/1ps

module px_int_seq (
	input logic got,	// Clock
	input logic clo_,	// General clear
	input logic cyc_end,	// Machine cycle end pulse
	input logic irq,	// Level interrupt request
	input px_pkg::px_state_t state,	// Current processor state
	output logic int_take,	// Enter I1 at the next boundary
	output px_pkg::px_state_t int_next,	// Phase successor
	output logic irq_ack	// Request accepted
);

	logic pending;	// Request seen and not yet served
	logic in_int;	// Some I phase active
	logic i1_end;	// Last cycle of I1

	assign in_int = |(state & px_pkg::PX_INT_MASK);
	assign i1_end = cyc_end & state[px_pkg::PX_I1];

	// Pending latch, served at the end of I1
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			pending <= 1'b0;
		end else if (i1_end) begin
			pending <= 1'b0;	// Entry done
		end else if (irq) begin
			pending <= 1'b1;
		end
	end

	assign int_take = pending & ~in_int;	// No nesting
	assign irq_ack = i1_end;	// One pulse per I1

	// I1 -> I2 -> I3 -> I4 -> I5 -> K1
	always_comb begin
		int_next = px_pkg::PX_ST_K1;	// Also after I5
		if (state[px_pkg::PX_I1]) begin
			int_next = px_pkg::PX_ST_I2;	// Save IC next
		end else if (state[px_pkg::PX_I2]) begin
			int_next = px_pkg::PX_ST_I3;	// Save SR next
		end else if (state[px_pkg::PX_I3]) begin
			int_next = px_pkg::PX_ST_I4;	// Vector read next
		end else if (state[px_pkg::PX_I4]) begin
			int_next = px_pkg::PX_ST_I5;
		end
	end

endmodule

/* hdl/px_state_reg.sv */
/*
	Processor state register
	Holds the one-hot state and picks the successor at each cycle end
*/
`timescale 1ns/1ps

module px_state_reg (
	input logic got,	// Clock
	input logic clo_,	// General clear
	input logic cyc_end,	// Machine cycle end pulse
	input px_pkg::px_instr_t instr,	// Instruction class, valid in K1
	input logic int_take,	// Interrupt wins after P1/WZ
	input px_pkg::px_state_t int_next,	// Successor in the I phases
	output px_pkg::px_state_t state	// Current processor state
);

	px_pkg::px_state_t nxt;	// Successor of the current state
	logic stores_q;	// Store flag kept from K1 until P1 ends

	// Successor choice, bad codes fall back to K1
	always_comb begin
		nxt = px_pkg::PX_ST_K1;
		if (state[px_pkg::PX_K1]) begin
			nxt = instr.has_arg ? px_pkg::PX_ST_K2 : px_pkg::PX_ST_P1;	// Argument or execute
		end else if (state[px_pkg::PX_K2]) begin
			nxt = px_pkg::PX_ST_P1;	// Argument in hand
		end else if (state[px_pkg::PX_P1] && stores_q) begin
			nxt = px_pkg::PX_ST_WZ;	// Result goes to memory
		end else if (state[px_pkg::PX_P1] || state[px_pkg::PX_WZ]) begin
			nxt = int_take ? px_pkg::PX_ST_I1 : px_pkg::PX_ST_K1;	// Instruction boundary
		end else if (|(state & px_pkg::PX_INT_MASK)) begin
			nxt = int_next;	// Interrupt phase chain
		end
	end

	// State flip-flops
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= px_pkg::PX_ST_K1;	// Start with a fetch
		end else if (cyc_end) begin
			state <= nxt;
		end
	end

	// Store flag sampled with the instruction at the end of K1
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			stores_q <= 1'b0;
		end else if (cyc_end && state[px_pkg::PX_K1]) begin
			stores_q <= instr.stores;
		end
	end

endmodule

/* hdl/px_pkg.sv */
/*
	P-X state control shared definitions
	One-hot state encoding, decoder and bus structs, state class masks
*/
package px_pkg;

	// One-hot bit positions of the processor state
	localparam int unsigned PX_K1 = 0;	// Instruction fetch, bus read
	localparam int unsigned PX_K2 = 1;	// Argument fetch, bus read
	localparam int unsigned PX_P1 = 2;	// Execute, no bus
	localparam int unsigned PX_WZ = 3;	// Result store, bus write
	localparam int unsigned PX_I1 = 4;	// Interrupt entry, no bus
	localparam int unsigned PX_I2 = 5;	// Save IC, bus write
	localparam int unsigned PX_I3 = 6;	// Save SR, bus write
	localparam int unsigned PX_I4 = 7;	// Vector read, bus read
	localparam int unsigned PX_I5 = 8;	// Interrupt end, no bus
	localparam int unsigned PX_NSTATES = 9;

	typedef logic [PX_NSTATES-1:0] px_state_t;	// Exactly one bit set

	// Single-state codes
	localparam px_state_t PX_ST_K1 = px_state_t'(1 << PX_K1);
	localparam px_state_t PX_ST_K2 = px_state_t'(1 << PX_K2);
	localparam px_state_t PX_ST_P1 = px_state_t'(1 << PX_P1);
	localparam px_state_t PX_ST_WZ = px_state_t'(1 << PX_WZ);
	localparam px_state_t PX_ST_I1 = px_state_t'(1 << PX_I1);
	localparam px_state_t PX_ST_I2 = px_state_t'(1 << PX_I2);
	localparam px_state_t PX_ST_I3 = px_state_t'(1 << PX_I3);
	localparam px_state_t PX_ST_I4 = px_state_t'(1 << PX_I4);
	localparam px_state_t PX_ST_I5 = px_state_t'(1 << PX_I5);

	// Instruction class from the decoder
	typedef struct packed {
		logic has_arg;	// Needs an argument word
		logic stores;	// Writes a result
	} px_instr_t;

	// System bus outputs
	typedef struct packed {
		logic req;	// ZG, bus request
		logic write;	// 1 write, 0 read
		logic [1:0] space;	// Address space
	} px_bus_t;

	localparam logic [1:0] PX_SPACE_CODE = 2'd0;
	localparam logic [1:0] PX_SPACE_DATA = 2'd1;
	localparam logic [1:0] PX_SPACE_INT = 2'd2;

	// State classes
	localparam px_state_t PX_BUS_READ_MASK = PX_ST_K1 | PX_ST_K2 | PX_ST_I4;
	localparam px_state_t PX_BUS_WRITE_MASK = PX_ST_WZ | PX_ST_I2 | PX_ST_I3;
	localparam px_state_t PX_INT_MASK = PX_ST_I1 | PX_ST_I2 | PX_ST_I3 | PX_ST_I4 | PX_ST_I5;

	// Internal operations get the long strobe 1
	localparam px_state_t px_state_is_long = PX_ST_P1 | PX_ST_I1 | PX_ST_I5;

endpackage
